/* pcs_rx_pkg.sv */
package pcs_rx_pkg;

        // Sync header of one 66-bit block. Only 01 and 10 are legal.
        typedef logic [1:0] sync_header_t;

        // Invalid header count inside one BER window.
        typedef logic [6:0] ber_count_t;

        // Position of the current block inside the BER window.
        typedef logic [9:0] window_count_t;

        // Header and invalid header counts of the lock state machine.
        typedef logic [5:0] lock_count_t;

        typedef logic [1:0] reg_addr_t;
        typedef logic [7:0] reg_data_t;

        localparam int HI_BER_VALUE     = 97;
        localparam int XUS_TIMER_WINDOW = 1024;
        localparam int LOCK_GOOD_COUNT  = 64;
        localparam int UNLOCK_BAD_COUNT = 16;

        // Host register map.
        localparam reg_addr_t REG_CONTROL   = 2'd0;
        localparam reg_addr_t REG_STATUS    = 2'd1;
        localparam reg_addr_t REG_ERR_COUNT = 2'd2;

endpackage

/* block_sync.sv */
`timescale 1ns/100ps

module block_sync
(
        input  logic                     i_clock,
        input  logic                     i_arst_n,
        input  logic                     i_block_valid,
        input  pcs_rx_pkg::sync_header_t i_sync_header,
        output logic                     o_block_strobe,
        output logic                     o_header_valid,
        output logic                     o_block_lock,
        output logic                     o_slip
);

        import pcs_rx_pkg::*;

        typedef enum logic [1:0]
        {
                LOCK_INIT,
                TEST_SH,
                GOOD_64,
                SLIP
        } state_t;

        localparam lock_count_t LAST_HEADER  = lock_count_t'(LOCK_GOOD_COUNT - 1);
        localparam lock_count_t LAST_INVALID = lock_count_t'(UNLOCK_BAD_COUNT - 1);

        state_t      state;
        state_t      next_state;
        lock_count_t sh_cnt;
        lock_count_t next_sh_cnt;
        lock_count_t sh_invld_cnt;
        lock_count_t next_sh_invld_cnt;
        logic        block_lock_next;
        logic        slip_next;

        // A header is legal when its two bits differ.
        always_ff @(posedge i_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        o_block_strobe <= 1'b0;
                        o_header_valid <= 1'b0;
                end
                else
                begin
                        o_block_strobe <= i_block_valid;
                        o_header_valid <= i_sync_header[1] ^ i_sync_header[0];
                end
        end

        // The lock decision works on the registered strobe and flag.
        always_comb
        begin
                next_state        = state;
                next_sh_cnt       = sh_cnt;
                next_sh_invld_cnt = sh_invld_cnt;
                block_lock_next   = o_block_lock;
                slip_next         = 1'b0;

                if (o_block_strobe)
                begin
                        if (!o_header_valid && (!o_block_lock || sh_invld_cnt == LAST_INVALID))
                        begin
                                // Hunting, or too many bad headers in this span.
                                next_state        = SLIP;
                                next_sh_cnt       = '0;
                                next_sh_invld_cnt = '0;
                                block_lock_next   = 1'b0;
                                slip_next         = 1'b1;
                        end
                        else if (sh_cnt == LAST_HEADER)
                        begin
                                next_state        = GOOD_64;
                                next_sh_cnt       = '0;
                                next_sh_invld_cnt = '0;
                                block_lock_next   = 1'b1;
                        end
                        else
                        begin
                                next_state  = TEST_SH;
                                next_sh_cnt = sh_cnt + lock_count_t'(1);
                                if (!o_header_valid)
                                        next_sh_invld_cnt = sh_invld_cnt + lock_count_t'(1);
                        end
                end
                else
                begin
                        case (state)
                                GOOD_64,
                                SLIP:
                                        next_state = TEST_SH;
                                default:
                                        next_state = state;
                        endcase
                end
        end

        always_ff @(posedge i_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        state        <= LOCK_INIT;
                        sh_cnt       <= '0;
                        sh_invld_cnt <= '0;
                        o_block_lock <= 1'b0;
                        o_slip       <= 1'b0;
                end
                else
                begin
                        state        <= next_state;
                        sh_cnt       <= next_sh_cnt;
                        sh_invld_cnt <= next_sh_invld_cnt;
                        o_block_lock <= block_lock_next;
                        o_slip       <= slip_next;
                end
        end

endmodule

/* ber_monitor.sv */
`timescale 1ns/100ps

module ber_monitor
(
        input  logic i_clock,
        input  logic i_arst_n,
        input  logic i_block_strobe,
        input  logic i_header_valid,
        input  logic i_block_lock,
        input  logic i_deskew_done,
        input  logic i_test_mode,
        output logic o_hi_ber
);

        import pcs_rx_pkg::*;

        typedef enum logic [1:0]
        {
                INIT,
                TEST,
                HI_BER
        } state_t;

        localparam window_count_t WINDOW_LAST = window_count_t'(XUS_TIMER_WINDOW - 1);
        localparam ber_count_t    BER_LIMIT   = ber_count_t'(HI_BER_VALUE);

        state_t        state;
        state_t        next_state;
        ber_count_t    ber_cnt;
        ber_count_t    ber_sum;
        ber_count_t    next_ber_cnt;
        window_count_t xus_timer;
        window_count_t next_xus_timer;
        logic          hi_ber_next;
        logic          count_en;
        logic          window_end;
        logic          ber_hit;

        assign count_en   = i_block_strobe && i_block_lock && (state != INIT);
        assign window_end = count_en && !i_test_mode && (xus_timer == WINDOW_LAST);

        // The error count saturates at the threshold.
        always_comb
        begin
                ber_sum = ber_cnt;
                if (count_en && !i_header_valid && ber_cnt != BER_LIMIT)
                        ber_sum = ber_cnt + ber_count_t'(1);
        end

        assign ber_hit      = (ber_sum == BER_LIMIT);
        assign next_ber_cnt = window_end ? '0 : ber_sum;

        // Test mode holds the timer, so the window never closes.
        always_comb
        begin
                next_xus_timer = xus_timer;
                if (window_end)
                        next_xus_timer = '0;
                else if (count_en && !i_test_mode)
                        next_xus_timer = xus_timer + window_count_t'(1);
        end

        always_comb
        begin
                next_state  = state;
                hi_ber_next = o_hi_ber;

                case (state)
                        INIT:
                        begin
                                if (i_block_strobe)
                                        next_state = TEST;
                        end
                        TEST:
                        begin
                                if (count_en && ber_hit)
                                begin
                                        next_state  = HI_BER;
                                        hi_ber_next = 1'b1;
                                end
                                else if (window_end)
                                        hi_ber_next = 1'b0;
                        end
                        HI_BER:
                        begin
                                if (window_end)
                                        next_state = TEST;
                        end
                        default:
                                next_state = INIT;
                endcase
        end

        always_ff @(posedge i_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        state     <= INIT;
                        ber_cnt   <= '0;
                        xus_timer <= '0;
                        o_hi_ber  <= 1'b0;
                end
                else if (!i_deskew_done)
                begin
                        state     <= INIT;
                        ber_cnt   <= '0;
                        xus_timer <= '0;
                        o_hi_ber  <= 1'b0;
                end
                else
                begin
                        state     <= next_state;
                        ber_cnt   <= next_ber_cnt;
                        xus_timer <= next_xus_timer;
                        o_hi_ber  <= hi_ber_next;
                end
        end

endmodule

/* pcs_rx_regs.sv */
`timescale 1ns/100ps

module pcs_rx_regs
(
        input  logic                  i_clock,
        input  logic                  i_arst_n,
        input  logic                  i_reg_write,
        input  logic                  i_reg_read,
        input  pcs_rx_pkg::reg_addr_t i_reg_addr,
        input  pcs_rx_pkg::reg_data_t i_reg_wdata,
        input  logic                  i_block_strobe,
        input  logic                  i_header_valid,
        input  logic                  i_block_lock,
        input  logic                  i_hi_ber,
        output logic                  o_test_mode,
        output pcs_rx_pkg::reg_data_t o_reg_rdata,
        output logic                  o_reg_rvalid
);

        import pcs_rx_pkg::*;

        reg_data_t err_count;
        logic      hi_ber_seen;
        logic      err_event;
        logic      read_status;
        logic      read_err_count;

        assign err_event      = i_block_strobe && i_block_lock && !i_header_valid;
        assign read_status    = i_reg_read && (i_reg_addr == REG_STATUS);
        assign read_err_count = i_reg_read && (i_reg_addr == REG_ERR_COUNT);

        always_ff @(posedge i_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        o_test_mode  <= 1'b0;
                        hi_ber_seen  <= 1'b0;
                        err_count    <= '0;
                        o_reg_rvalid <= 1'b0;
                end
                else
                begin
                        o_reg_rvalid <= i_reg_read;

                        if (i_reg_write && i_reg_addr == REG_CONTROL)
                                o_test_mode <= i_reg_wdata[0];

                        // A read clears the sticky bit unless hi_ber is still up.
                        if (read_status)
                                hi_ber_seen <= i_hi_ber;
                        else if (i_hi_ber)
                                hi_ber_seen <= 1'b1;

                        // An error in the same cycle as the read is kept.
                        if (read_err_count)
                                err_count <= reg_data_t'(err_event);
                        else if (err_event && err_count != '1)
                                err_count <= err_count + reg_data_t'(1);
                end
        end

        always_ff @(posedge i_clock)
        begin
                case (i_reg_addr)
                        REG_CONTROL:   o_reg_rdata <= {7'd0, o_test_mode};
                        REG_STATUS:    o_reg_rdata <= {5'd0, hi_ber_seen, i_hi_ber, i_block_lock};
                        REG_ERR_COUNT: o_reg_rdata <= err_count;
                        default:       o_reg_rdata <= '0;
                endcase
        end

endmodule

/* pcs_rx_lane.sv */
`timescale 1ns/100ps

module pcs_rx_lane
(
        input  logic                     i_clock,
        input  logic                     i_arst_n,
        input  logic                     i_block_valid,
        input  pcs_rx_pkg::sync_header_t i_sync_header,
        input  logic                     i_deskew_done,
        input  logic                     i_reg_write,
        input  logic                     i_reg_read,
        input  pcs_rx_pkg::reg_addr_t    i_reg_addr,
        input  pcs_rx_pkg::reg_data_t    i_reg_wdata,
        output logic                     o_slip,
        output logic                     o_block_lock,
        output logic                     o_hi_ber,
        output pcs_rx_pkg::reg_data_t    o_reg_rdata,
        output logic                     o_reg_rvalid
);

        logic block_strobe;
        logic header_valid;
        logic test_mode;

        block_sync u_block_sync
        (
                .i_clock        (i_clock),
                .i_arst_n       (i_arst_n),
                .i_block_valid  (i_block_valid),
                .i_sync_header  (i_sync_header),
                .o_block_strobe (block_strobe),
                .o_header_valid (header_valid),
                .o_block_lock   (o_block_lock),
                .o_slip         (o_slip)
        );

        ber_monitor u_ber_monitor
        (
                .i_clock        (i_clock),
                .i_arst_n       (i_arst_n),
                .i_block_strobe (block_strobe),
                .i_header_valid (header_valid),
                .i_block_lock   (o_block_lock),
                .i_deskew_done  (i_deskew_done),
                .i_test_mode    (test_mode),
                .o_hi_ber       (o_hi_ber)
        );

        pcs_rx_regs u_pcs_rx_regs
        (
                .i_clock        (i_clock),
                .i_arst_n       (i_arst_n),
                .i_reg_write    (i_reg_write),
                .i_reg_read     (i_reg_read),
                .i_reg_addr     (i_reg_addr),
                .i_reg_wdata    (i_reg_wdata),
                .i_block_strobe (block_strobe),
                .i_header_valid (header_valid),
                .i_block_lock   (o_block_lock),
                .i_hi_ber       (o_hi_ber),
                .o_test_mode    (test_mode),
                .o_reg_rdata    (o_reg_rdata),
                .o_reg_rvalid   (o_reg_rvalid)
        );

endmodule

/* pcs_rx_checker.sv */
`timescale 1ns/100ps

module pcs_rx_checker
(
        input logic i_clock,
        input logic i_arst_n,
        input logic i_block_strobe,
        input logic i_header_valid,
        input logic i_block_lock,
        input logic i_slip,
        input logic i_hi_ber,
        input logic i_deskew_done,
        input logic i_reg_read,
        input logic i_reg_rvalid
);

        // Outputs hold their reset values while reset is asserted.
        reset_values: assert property (@(posedge i_clock)
                !i_arst_n |-> !i_slip && !i_block_lock && !i_hi_ber && !i_reg_rvalid)
                else $error("Outputs left their reset values during reset");

        lock_after_valid: assert property (@(posedge i_clock) disable iff (!i_arst_n)
                $rose(i_block_lock) |-> $past(i_block_strobe && i_header_valid))
                else $error("Block lock rose without a valid header strobe");

        slip_when_unlocked: assert property (@(posedge i_clock) disable iff (!i_arst_n)
                i_slip |-> !i_block_lock)
                else $error("Slip requested while block lock is held");

        read_response: assert property (@(posedge i_clock) disable iff (!i_arst_n)
                i_reg_read |=> i_reg_rvalid)
                else $error("Register read gave no response one cycle later");

        // A lane that is not deskewed never reports hi_ber.
        hi_ber_deskew: assert property (@(posedge i_clock) disable iff (!i_arst_n)
                !i_deskew_done |=> !i_hi_ber)
                else $error("hi_ber high while deskew is not done");

        hi_ber_locked: assert property (@(posedge i_clock) disable iff (!i_arst_n)
                $rose(i_hi_ber) |-> $past(i_block_lock))
                else $error("hi_ber rose while the lane was unlocked");

endmodule

bind pcs_rx_lane pcs_rx_checker u_pcs_rx_checker
(
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_block_strobe (block_strobe),
        .i_header_valid (header_valid),
        .i_block_lock   (o_block_lock),
        .i_slip         (o_slip),
        .i_hi_ber       (o_hi_ber),
        .i_deskew_done  (i_deskew_done),
        .i_reg_read     (i_reg_read),
        .i_reg_rvalid   (o_reg_rvalid)
);

/* tb_pcs_rx_lane.sv */
`timescale 1ns/100ps

module tb_pcs_rx_lane;

        import pcs_rx_pkg::*;

        localparam int MAX_SEGMENTS = 16;

        logic         i_clock;
        logic         i_arst_n;
        logic         i_block_valid;
        sync_header_t i_sync_header;
        logic         i_deskew_done;
        logic         i_reg_write;
        logic         i_reg_read;
        reg_addr_t    i_reg_addr;
        reg_data_t    i_reg_wdata;
        logic         o_slip;
        logic         o_block_lock;
        logic         o_hi_ber;
        reg_data_t    o_reg_rdata;
        logic         o_reg_rvalid;

        string seg_name [MAX_SEGMENTS];
        int    seg_blocks [MAX_SEGMENTS];
        int    seg_period [MAX_SEGMENTS];
        int    seg_deskew [MAX_SEGMENTS];
        int    seg_test [MAX_SEGMENTS];
        int    exp_lock [MAX_SEGMENTS];
        int    exp_hi_ber [MAX_SEGMENTS];
        int    exp_seen [MAX_SEGMENTS];
        int    exp_err [MAX_SEGMENTS];
        int    seg_total;
        int    error_count;
        int    failed_tests;
        int    cycle_count = 0;
        int    cycle_limit = 0;
        int    slip_total = 0;

        // Reference lock state, kept per received header from the lock rules.
        bit    model_lock;
        int    hdr_count;
        int    bad_count;
        int    err_model;
        int    slip_model;

        pcs_rx_lane UUT
        (
                .i_clock       (i_clock),
                .i_arst_n      (i_arst_n),
                .i_block_valid (i_block_valid),
                .i_sync_header (i_sync_header),
                .i_deskew_done (i_deskew_done),
                .i_reg_write   (i_reg_write),
                .i_reg_read    (i_reg_read),
                .i_reg_addr    (i_reg_addr),
                .i_reg_wdata   (i_reg_wdata),
                .o_slip        (o_slip),
                .o_block_lock  (o_block_lock),
                .o_hi_ber      (o_hi_ber),
                .o_reg_rdata   (o_reg_rdata),
                .o_reg_rvalid  (o_reg_rvalid)
        );

        initial
        begin
                i_clock = 1'b0;
                forever #20 i_clock = ~i_clock;
        end

        always @(posedge i_clock)
        begin
                cycle_count++;
                if (cycle_limit > 0 && cycle_count > cycle_limit)
                begin
                        $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
                        $display("TESTS FAILED");
                        $finish;
                end
        end

        always @(negedge i_clock)
        begin
                if (o_slip)
                        slip_total <= slip_total + 1;
        end

        task automatic check_value(input string test, input string what,
                                   input int expected, input int actual);
                if (expected != actual)
                begin
                        $display("ERROR %s %s: expected %0d, actual %0d",
                                 test, what, expected, actual);
                        error_count++;
                end
        endtask

        function automatic sync_header_t pick_header(input bit bad);
                bit [31:0] r;
                r = $urandom();
                if (bad)
                        return r[0] ? 2'b11 : 2'b00;
                return r[0] ? 2'b10 : 2'b01;
        endfunction

        // With test mode set, two clean windows follow the errors and hi_ber must stay up.
        function automatic int test_mode_tail(input int s);
                return (seg_test[s] != 0) ? 2 * XUS_TIMER_WINDOW : 0;
        endfunction

        // Lock is won by 64 good headers in a row and lost by 16 bad ones in a span.
        task automatic count_block(input bit bad);
                if (bad && model_lock)
                        err_model++;
                if (bad && !model_lock)
                begin
                        slip_model++;
                        hdr_count = 0;
                        bad_count = 0;
                end
                else
                begin
                        hdr_count++;
                        if (bad)
                                bad_count++;
                        if (bad_count == UNLOCK_BAD_COUNT)
                        begin
                                model_lock = 1'b0;
                                slip_model++;
                                hdr_count = 0;
                                bad_count = 0;
                        end
                        else if (hdr_count == LOCK_GOOD_COUNT)
                        begin
                                model_lock = 1'b1;
                                hdr_count = 0;
                                bad_count = 0;
                        end
                end
        endtask

        task automatic write_control(input int value);
                @(posedge i_clock);
                i_reg_write <= 1'b1;
                i_reg_addr  <= REG_CONTROL;
                i_reg_wdata <= reg_data_t'(value);
                @(posedge i_clock);
                i_reg_write <= 1'b0;
        endtask

        task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
                @(posedge i_clock);
                i_reg_read <= 1'b1;
                i_reg_addr <= addr;
                @(posedge i_clock);
                i_reg_read <= 1'b0;
                @(negedge i_clock);
                while (!o_reg_rvalid)
                        @(negedge i_clock);
                data = o_reg_rdata;
        endtask

        task automatic load_segments();
                int              fd;
                int              fields;
                string           line;
                logic [8*16-1:0] name_buf;
                fd = $fopen("pcs_rx_input.txt", "r");
                if (fd == 0)
                begin
                        $display("The stimulus file pcs_rx_input.txt could not be opened");
                        error_count++;
                end
                else
                begin
                        while (!$feof(fd) && seg_total < MAX_SEGMENTS)
                        begin
                                line = "";
                                fields = $fgets(line, fd);
                                if (line.len() > 1 && line.getc(0) != "#")
                                begin
                                        fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d",
                                                name_buf,
                                                seg_blocks[seg_total], seg_period[seg_total],
                                                seg_deskew[seg_total], seg_test[seg_total],
                                                exp_lock[seg_total], exp_hi_ber[seg_total],
                                                exp_seen[seg_total], exp_err[seg_total]);
                                        if (fields == 9)
                                        begin
                                                seg_name[seg_total] = $sformatf("%0s", name_buf);
                                                seg_total++;
                                        end
                                        else
                                        begin
                                                $display("A line of the stimulus file is malformed");
                                                error_count++;
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic run_segment(input int s);
                int        i;
                int        ofs;
                int        tail;
                int        slip_base;
                int        errors_before;
                bit        bad;
                reg_data_t status;
                reg_data_t err_reg;
                errors_before = error_count;
                ofs = (seg_period[s] > 0) ? int'($urandom() % seg_period[s]) : 0;
                tail = test_mode_tail(s);
                err_model = 0;
                slip_model = 0;
                @(posedge i_clock);
                i_deskew_done <= (seg_deskew[s] != 0);
                write_control(seg_test[s]);
                slip_base = slip_total;
                for (i = 1; i <= seg_blocks[s] + tail; i++)
                begin
                        bad = (i <= seg_blocks[s]) && (seg_period[s] > 0) &&
                              ((i + ofs) % seg_period[s] == 0);
                        @(posedge i_clock);
                        i_block_valid <= 1'b1;
                        i_sync_header <= pick_header(bad);
                        count_block(bad);
                end
                @(posedge i_clock);
                i_block_valid <= 1'b0;
                // The last block reaches lock and slip two cycles after it is sent.
                repeat (3) @(posedge i_clock);
                @(negedge i_clock);
                check_value(seg_name[s], "block_lock", exp_lock[s], int'(o_block_lock));
                check_value(seg_name[s], "hi_ber", exp_hi_ber[s], int'(o_hi_ber));
                check_value(seg_name[s], "slip pulses", slip_model, slip_total - slip_base);
                read_reg(REG_STATUS, status);
                check_value(seg_name[s], "status lock", exp_lock[s], int'(status[0]));
                check_value(seg_name[s], "status hi_ber", exp_hi_ber[s], int'(status[1]));
                check_value(seg_name[s], "status hi_ber seen", exp_seen[s], int'(status[2]));
                read_reg(REG_ERR_COUNT, err_reg);
                check_value(seg_name[s], "errored blocks", (err_model > 255) ? 255 : err_model,
                            int'(err_reg));
                if (exp_err[s] >= 0)
                        check_value(seg_name[s], "errored blocks listed", exp_err[s], int'(err_reg));
                // The read above leaves the sticky bit equal to the live hi_ber.
                read_reg(REG_STATUS, status);
                check_value(seg_name[s], "hi_ber seen after read", exp_hi_ber[s], int'(status[2]));
                if (error_count == errors_before)
                        $display("Test %s: ok", seg_name[s]);
                else
                begin
                        $display("Test %s: failed", seg_name[s]);
                        failed_tests++;
                end
        endtask

        initial
        begin
                int        s;
                int        errors_before;
                reg_data_t data;
                void'($urandom(87));
                i_arst_n = 1'b0;
                i_block_valid = 1'b0;
                i_sync_header = 2'b01;
                i_deskew_done = 1'b0;
                i_reg_write = 1'b0;
                i_reg_read = 1'b0;
                i_reg_addr = '0;
                i_reg_wdata = '0;
                error_count = 0;
                failed_tests = 0;
                seg_total = 0;
                model_lock = 1'b0;
                hdr_count = 0;
                bad_count = 0;
                load_segments();
                if (seg_total == 0)
                begin
                        $display("The stimulus file holds no tests");
                        error_count++;
                end
                cycle_limit = 200;
                for (s = 0; s < seg_total; s++)
                        cycle_limit += seg_blocks[s] + test_mode_tail(s) + 40;
                repeat (10) @(posedge i_clock);
                i_arst_n <= 1'b1;
                for (s = 0; s < seg_total; s++)
                        run_segment(s);
                errors_before = error_count;
                write_control(1);
                read_reg(REG_CONTROL, data);
                check_value("registers", "control", 1, int'(data));
                read_reg(2'd3, data);
                check_value("registers", "unused address", 0, int'(data));
                write_control(0);
                read_reg(REG_CONTROL, data);
                check_value("registers", "control cleared", 0, int'(data));
                if (error_count == errors_before)
                        $display("Test registers: ok");
                else
                begin
                        $display("Test registers: failed");
                        failed_tests++;
                end
                $display("%0d tests run, %0d failed, %0d errors", seg_total + 1, failed_tests,
                         error_count);
                if (error_count == 0)
                        $display("TESTS PASSED");
                else
                        $display("TESTS FAILED");
                $finish;
        end

endmodule

/* pcs_rx_input.txt */
# name blocks invalid_period deskew_done test_mode lock hi_ber hi_ber_seen err_count
# Period 0 sends no invalid headers. An err_count of -1 uses the count kept by the testbench.
clean_lock     100  0 1 0 1 0 0 0
hi_ber_rise   1024  8 1 0 1 1 1 128
hi_ber_clear  1100  0 1 0 1 0 1 0
lock_loss      200  2 1 0 0 0 0 -1
relock         100  0 1 0 1 0 0 0
deskew_low    1024  8 0 0 1 0 0 128
test_mode     2048  8 1 1 1 1 1 255
recover       2100  0 1 0 1 0 1 0

/* verilog.f */
pcs_rx_pkg.sv
block_sync.sv
ber_monitor.sv
pcs_rx_regs.sv
pcs_rx_lane.sv
pcs_rx_checker.sv
tb_pcs_rx_lane.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_pcs_rx_lane
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
